// File: rtl/usb_rx_macros.svh
////////////////////////////////////////
// USB receive monitor constants
// Bus widths, RX CMD field positions,
// CRC16 residue and address check default
////////////////////////////////////////
`ifndef USB_RX_MACROS_SVH
`define USB_RX_MACROS_SVH

// ULPI data bus width
`define USB_RX_BYTE_W 8

// UTMI line state width
`define USB_RX_LINESTATE_W 2

// RX CMD byte layout
// Line state sits in bits 1:0 and RxEvent in bits 5:4
`define USB_RX_CMD_LS_LSB 0
`define USB_RX_CMD_EVT_LSB 4
`define USB_RX_CMD_EVT_W 2

// Remainder of a good DATA packet run through the CRC16 with its CRC bytes
// Bit-reversed form of 16'h800D since the register shifts LSB first
`define USB_RX_CRC16_RESIDUAL 16'hB001

// Address filter on by default
`define USB_RX_ADDR_CHECK_DEFAULT 1'b1

`endif

// File: rtl/usb_rx_pkg.sv
////////////////////////////////////////
// USB receive monitor types
// PID codes, line state, decoder phase
// and the CRC5 / CRC16 helpers
////////////////////////////////////////
`include "usb_rx_macros.svh"

package usb_rx_pkg;

    // PID as carried in the low nibble of the PID byte
    typedef enum logic [3:0] {
        PID_RSVD  = 4'b0000,
        PID_OUT   = 4'b0001,
        PID_ACK   = 4'b0010,
        PID_DATA0 = 4'b0011,
        PID_PING  = 4'b0100,
        PID_SOF   = 4'b0101,
        PID_NYET  = 4'b0110,
        PID_DATA2 = 4'b0111,
        PID_SPLIT = 4'b1000,
        PID_IN    = 4'b1001,
        PID_NAK   = 4'b1010,
        PID_DATA1 = 4'b1011,
        PID_ERR   = 4'b1100,
        PID_SETUP = 4'b1101,
        PID_STALL = 4'b1110,
        PID_MDATA = 4'b1111
    } pid_t;

    typedef enum logic [`USB_RX_LINESTATE_W-1:0] {
        LS_SE0 = 2'b00,
        LS_J   = 2'b01,
        LS_K   = 2'b10,
        LS_SE1 = 2'b11
    } linestate_t;

    typedef enum logic [2:0] {
        PH_PID,
        PH_DATA,
        PH_TOKEN_B0,
        PH_TOKEN_B1,
        PH_SOF_B0,
        PH_SOF_B1,
        PH_ERROR,
        PH_NONE
    } rx_phase_t;

    // CRC5 over address and endpoint, bit 0 first on the wire
    // Result is bit-ordered as it appears in bits 7:3 of the second token byte
    function automatic logic [4:0] crc5_token(input logic [10:0] bits);
        logic [4:0] crc;
        logic       fb;
        int         i;
        crc = 5'h1f;
        for (i = 0; i < 11; i++) begin
            fb  = crc[4] ^ bits[i];
            crc = {crc[3:0], 1'b0};
            if (fb) begin
                crc = crc ^ 5'b00101;
            end
        end
        crc = ~crc;
        return {crc[0], crc[1], crc[2], crc[3], crc[4]};
    endfunction

    // One byte through the reflected CRC16 (poly 8005 reversed)
    function automatic logic [15:0] crc16_step(input logic [15:0]               crc_in,
                                               input logic [`USB_RX_BYTE_W-1:0] data);
        logic [15:0] crc;
        logic        fb;
        int          i;
        crc = crc_in;
        for (i = 0; i < `USB_RX_BYTE_W; i++) begin
            fb  = crc[0] ^ data[i];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ 16'hA001;
            end
        end
        return crc;
    endfunction

endpackage

// File: rtl/ulpi_rxcmd_decoder.sv
`timescale 1ns/100ps
////////////////////////////////////////
// ULPI RX CMD decoder
// Tracks dir turnarounds, splits RX CMD
// bytes from packet bytes, holds status
////////////////////////////////////////
`include "usb_rx_macros.svh"

module ulpi_rxcmd_decoder (
    input  logic                      phy_clk,
    input  logic                      reset,
    input  logic [`USB_RX_BYTE_W-1:0] phy_di,
    input  logic                      phy_dir,
    input  logic                      phy_nxt,
    output logic                      byte_strobe,
    output logic [`USB_RX_BYTE_W-1:0] byte_data,
    output logic                      rx_active,
    output logic                      rx_error,
    output usb_rx_pkg::linestate_t    linestate,
    output logic                      host_disconnected
);
    import usb_rx_pkg::*;

    logic                         dir_prev;
    logic                         turnaround;
    logic                         dir_fall;
    logic                         rxcmd_valid;
    logic                         data_valid;
    logic [`USB_RX_CMD_EVT_W-1:0] rx_event;

    // The cycle in which the PHY takes the bus carries nothing
    assign turnaround  = phy_dir && !dir_prev;
    assign dir_fall    = !phy_dir && dir_prev;
    assign rxcmd_valid = phy_dir && dir_prev && !phy_nxt;
    assign data_valid  = phy_dir && dir_prev && phy_nxt;
    assign rx_event    = phy_di[`USB_RX_CMD_EVT_LSB +: `USB_RX_CMD_EVT_W];

    always_ff @(posedge phy_clk) begin
        if (reset) begin
            dir_prev          <= 1'b0;
            byte_strobe       <= 1'b0;
            rx_active         <= 1'b0;
            rx_error          <= 1'b0;
            linestate         <= LS_SE1;
            host_disconnected <= 1'b1;
        end else begin
            dir_prev    <= phy_dir;
            byte_strobe <= data_valid;

            if (turnaround) begin
                // nxt high here means a packet is already starting
                rx_active <= phy_nxt;
                rx_error  <= 1'b0;
            end else if (rxcmd_valid) begin
                linestate <= linestate_t'(phy_di[`USB_RX_CMD_LS_LSB +: `USB_RX_LINESTATE_W]);
                case (rx_event)
                    2'b00: begin
                        rx_active         <= 1'b0;
                        rx_error          <= 1'b0;
                        host_disconnected <= 1'b0;
                    end
                    2'b01: begin
                        rx_active         <= 1'b1;
                        rx_error          <= 1'b0;
                        host_disconnected <= 1'b0;
                    end
                    2'b11: begin
                        rx_active         <= 1'b1;
                        rx_error          <= 1'b1;
                        host_disconnected <= 1'b0;
                    end
                    default: begin
                        // Host disconnect leaves active and error low
                        rx_active         <= 1'b0;
                        rx_error          <= 1'b0;
                        host_disconnected <= 1'b1;
                    end
                endcase
            end else if (dir_fall) begin
                // Losing the bus ends any packet in flight
                rx_active <= 1'b0;
                rx_error  <= 1'b0;
            end
        end
    end

    // Packet byte capture
    always_ff @(posedge phy_clk) begin
        if (data_valid) begin
            byte_data <= phy_di;
        end
    end

    // Turnaround sample must never come out as a packet byte
    a_no_byte_after_turnaround: assert property (
        @(posedge phy_clk) disable iff (reset)
        $rose(phy_dir) |=> !byte_strobe
    );

endmodule

// File: rtl/usb_crc16_checker.sv
`timescale 1ns/100ps
////////////////////////////////////////
// USB CRC16 checker
// Running CRC over DATA packet bytes
////////////////////////////////////////
`include "usb_rx_macros.svh"

module usb_crc16_checker (
    input  logic                      phy_clk,
    input  logic                      reset,
    input  logic                      crc_clear,
    input  logic                      crc_strobe,
    input  logic [`USB_RX_BYTE_W-1:0] crc_data,
    output logic                      crc_ok
);
    import usb_rx_pkg::*;

    logic [15:0] crc_reg;

    // Preset to all ones at each PID and stepped once per byte
    always_ff @(posedge phy_clk) begin
        if (reset) begin
            crc_reg <= 16'hFFFF;
        end else if (crc_clear) begin
            crc_reg <= 16'hFFFF;
        end else if (crc_strobe) begin
            crc_reg <= crc16_step(crc_reg, crc_data);
        end
    end

    // Good once the CRC bytes themselves have been folded in
    assign crc_ok = (crc_reg == `USB_RX_CRC16_RESIDUAL);

endmodule

// File: rtl/usb_rx_packet_decoder.sv
`timescale 1ns/100ps
////////////////////////////////////////
// USB receive packet decoder
// PID check, token CRC5 and address
// filter, handshakes, DATA with CRC16
////////////////////////////////////////
`include "usb_rx_macros.svh"

module usb_rx_packet_decoder #(
    parameter bit addr_check_en = `USB_RX_ADDR_CHECK_DEFAULT
) (
    input  logic                      phy_clk,
    input  logic                      reset,
    input  logic                      byte_strobe,
    input  logic [`USB_RX_BYTE_W-1:0] byte_data,
    input  logic                      rx_active,
    input  logic                      rx_error,
    input  logic [6:0]                cfg_usb_addr,
    output logic [`USB_RX_BYTE_W-1:0] rx_data,
    output logic                      rx_valid,
    output logic                      rx_last,
    output logic                      rx_error_flag
);
    import usb_rx_pkg::*;

    rx_phase_t                 phase;
    pid_t                      pid;
    logic                      rx_active_prev;
    logic                      pkt_start;
    logic                      pkt_end;
    logic                      pkt_error;
    logic                      filter;
    logic [1:0]                count;
    logic [`USB_RX_BYTE_W-1:0] hist1;
    logic [`USB_RX_BYTE_W-1:0] hist2;
    logic [`USB_RX_BYTE_W-1:0] hist3;
    logic                      pid_bad;
    logic [10:0]               token_bits;
    logic                      token_pass;
    logic                      crc_clear;
    logic                      crc_strobe;
    logic                      crc_ok;

    assign pkt_start = rx_active && !rx_active_prev;
    assign pkt_end   = !rx_active && rx_active_prev;

    assign pid     = pid_t'(byte_data[3:0]);
    assign pid_bad = (byte_data[7:4] != ~byte_data[3:0]);

    // Second token byte is current, first one is in hist1
    assign token_bits = {byte_data[2:0], hist1};
    assign token_pass = (crc5_token(token_bits) == byte_data[7:3]) &&
                        (!addr_check_en || (hist1[6:0] == cfg_usb_addr));

    assign crc_clear  = byte_strobe && (phase == PH_PID);
    assign crc_strobe = byte_strobe && (phase == PH_DATA);

    usb_crc16_checker crc16_i (
        .phy_clk    (phy_clk),
        .reset      (reset),
        .crc_clear  (crc_clear),
        .crc_strobe (crc_strobe),
        .crc_data   (byte_data),
        .crc_ok     (crc_ok)
    );

    // Last three bytes of the packet
    always_ff @(posedge phy_clk) begin
        if (byte_strobe) begin
            hist1 <= byte_data;
            hist2 <= hist1;
            hist3 <= hist2;
        end
    end

    always_ff @(posedge phy_clk) begin
        if (reset) begin
            rx_valid       <= 1'b0;
            rx_last        <= 1'b0;
            rx_active_prev <= 1'b0;
            pkt_error      <= 1'b0;
            phase          <= PH_NONE;
            filter         <= 1'b0;
            count          <= 2'd0;
        end else begin
            rx_valid       <= 1'b0;
            rx_last        <= 1'b0;
            rx_active_prev <= rx_active;

            // Error seen anywhere inside the packet sticks until the next one
            if (pkt_start) begin
                phase     <= PH_PID;
                pkt_error <= rx_error;
            end else begin
                pkt_error <= pkt_error || rx_error;
            end

            if (byte_strobe) begin
                case (phase)
                    PH_PID: begin
                        count <= 2'd0;
                        if (pid_bad) begin
                            phase  <= PH_ERROR;
                            filter <= 1'b0;
                        end else begin
                            case (pid)
                                PID_ACK, PID_NAK, PID_STALL, PID_NYET: begin
                                    phase         <= PH_NONE;
                                    rx_data       <= {4'h0, byte_data[3:0]};
                                    rx_valid      <= filter;
                                    rx_last       <= filter;
                                    rx_error_flag <= 1'b0;
                                end
                                PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA: begin
                                    phase <= filter ? PH_DATA : PH_NONE;
                                end
                                PID_OUT, PID_IN, PID_SETUP, PID_PING: begin
                                    phase <= PH_TOKEN_B0;
                                end
                                PID_SOF: begin
                                    phase <= PH_SOF_B0;
                                end
                                default: begin
                                    // SPLIT and the rest are skipped to packet end
                                    phase <= PH_ERROR;
                                end
                            endcase
                        end
                    end
                    PH_DATA: begin
                        // Hold back two bytes since they may turn out to be the CRC
                        if (count == 2'd3) begin
                            rx_data       <= hist3;
                            rx_valid      <= 1'b1;
                            rx_error_flag <= 1'b0;
                        end else begin
                            count <= count + 2'd1;
                        end
                    end
                    PH_TOKEN_B0: begin
                        phase <= PH_TOKEN_B1;
                    end
                    PH_TOKEN_B1: begin
                        phase         <= PH_NONE;
                        filter        <= token_pass;
                        rx_data       <= {byte_data[2:0], hist1[7], hist2[3:0]};
                        rx_valid      <= token_pass;
                        rx_last       <= token_pass;
                        rx_error_flag <= 1'b0;
                    end
                    PH_SOF_B0: begin
                        phase <= PH_SOF_B1;
                    end
                    PH_SOF_B1: begin
                        phase <= PH_NONE;
                    end
                    default: begin
                        // Wait for rx_active to drop
                        phase <= phase;
                    end
                endcase
            end

            if (pkt_end) begin
                if ((phase == PH_DATA) && (count == 2'd3)) begin
                    rx_data       <= hist3;
                    rx_valid      <= 1'b1;
                    rx_last       <= 1'b1;
                    rx_error_flag <= pkt_error || !crc_ok;
                end
                phase <= PH_NONE;
            end
        end
    end

    a_last_has_valid: assert property (
        @(posedge phy_clk) disable iff (reset)
        rx_last |-> rx_valid
    );

endmodule

// File: rtl/usb_rx.sv
`timescale 1ns/100ps
////////////////////////////////////////
// USB 2.0 receive link monitor
// ULPI RX CMD decoder feeding the
// packet decoder
////////////////////////////////////////
`include "usb_rx_macros.svh"

module usb_rx (
    input  logic                      phy_clk,
    input  logic                      reset,
    input  logic [`USB_RX_BYTE_W-1:0] phy_di,
    input  logic                      phy_dir,
    input  logic                      phy_nxt,
    input  logic [6:0]                cfg_usb_addr,
    output logic [`USB_RX_BYTE_W-1:0] rx_data,
    output logic                      rx_valid,
    output logic                      rx_last,
    output logic                      rx_error_flag,
    output usb_rx_pkg::linestate_t    linestate,
    output logic                      host_disconnected
);

    // Byte stream and UTMI status between the two stages
    logic                      byte_strobe;
    logic [`USB_RX_BYTE_W-1:0] byte_data;
    logic                      rx_active;
    logic                      rx_error;

    ulpi_rxcmd_decoder rxcmd_i (
        .phy_clk           (phy_clk),
        .reset             (reset),
        .phy_di            (phy_di),
        .phy_dir           (phy_dir),
        .phy_nxt           (phy_nxt),
        .byte_strobe       (byte_strobe),
        .byte_data         (byte_data),
        .rx_active         (rx_active),
        .rx_error          (rx_error),
        .linestate         (linestate),
        .host_disconnected (host_disconnected)
    );

    usb_rx_packet_decoder packet_i (
        .phy_clk       (phy_clk),
        .reset         (reset),
        .byte_strobe   (byte_strobe),
        .byte_data     (byte_data),
        .rx_active     (rx_active),
        .rx_error      (rx_error),
        .cfg_usb_addr  (cfg_usb_addr),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .rx_last       (rx_last),
        .rx_error_flag (rx_error_flag)
    );

endmodule

// File: dv/usb_rx_tb_packets.svh
////////////////////////////////////////
// USB receive monitor stimulus table
// ULPI packets, expected beats and
// bit-serial CRC reference models
////////////////////////////////////////
`ifndef USB_RX_TB_PACKETS_SVH
`define USB_RX_TB_PACKETS_SVH

localparam logic [1:0] CRC_NONE = 2'd0;
localparam logic [1:0] CRC_5    = 2'd1;
localparam logic [1:0] CRC_16   = 2'd2;

// Byte i of pkt and beat i of exp_data sit at bits 8*i+7:8*i
// CRC fields are filled in by the driver, pkt holds zeros there
typedef struct packed {
    linestate_t  ls;
    logic [2:0]  nbytes;
    logic [47:0] pkt;
    logic [1:0]  crc_kind;
    logic        bad_crc;
    logic        err_cmd;
    logic [2:0]  exp_n;
    logic [31:0] exp_data;
    logic        exp_err;
} pkt_entry_t;

localparam int NUM_PKTS = 17;

// Device address 7'h2A
// ls, nbytes, pkt, crc, bad crc, error cmd, beats, beat data, last beat error
pkt_entry_t pkt_table [NUM_PKTS] = '{
    '{LS_J,   3'd3, 48'h00_00_00_00_AA_E1, CRC_5,    1'b0, 1'b0, 3'd1, 32'h00_00_00_11, 1'b0},
    '{LS_K,   3'd4, 48'h00_00_33_22_11_C3, CRC_16,   1'b0, 1'b0, 3'd3, 32'h00_33_22_11, 1'b0},
    '{LS_J,   3'd1, 48'h00_00_00_00_00_D2, CRC_NONE, 1'b0, 1'b0, 3'd1, 32'h00_00_00_02, 1'b0},
    '{LS_SE0, 3'd5, 48'h00_F0_0F_5A_A5_4B, CRC_16,   1'b1, 1'b0, 3'd4, 32'hF0_0F_5A_A5, 1'b1},
    '{LS_K,   3'd3, 48'h00_00_00_88_77_C3, CRC_16,   1'b0, 1'b1, 3'd2, 32'h00_00_88_77, 1'b1},
    // Wrong address drops the filter
    '{LS_J,   3'd3, 48'h00_00_00_01_15_69, CRC_5,    1'b0, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0},
    '{LS_J,   3'd1, 48'h00_00_00_00_00_5A, CRC_NONE, 1'b0, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0},
    '{LS_K,   3'd3, 48'h00_00_00_02_01_4B, CRC_16,   1'b0, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0},
    '{LS_J,   3'd3, 48'h00_00_00_01_AA_2D, CRC_5,    1'b0, 1'b0, 3'd1, 32'h00_00_00_3D, 1'b0},
    '{LS_K,   3'd2, 48'h00_00_00_00_5E_C3, CRC_16,   1'b0, 1'b0, 3'd1, 32'h00_00_00_5E, 1'b0},
    // Corrupted CRC5 drops the filter
    '{LS_J,   3'd3, 48'h00_00_00_00_2A_2D, CRC_5,    1'b1, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0},
    '{LS_J,   3'd1, 48'h00_00_00_00_00_D2, CRC_NONE, 1'b0, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0},
    '{LS_SE0, 3'd3, 48'h00_00_00_01_2A_B4, CRC_5,    1'b0, 1'b0, 3'd1, 32'h00_00_00_24, 1'b0},
    '{LS_J,   3'd3, 48'h00_00_00_01_23_A5, CRC_5,    1'b0, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0},
    '{LS_K,   3'd1, 48'h00_00_00_00_00_96, CRC_NONE, 1'b0, 1'b0, 3'd1, 32'h00_00_00_06, 1'b0},
    // PID with a broken complement, then DATA that must be ignored
    '{LS_J,   3'd1, 48'h00_00_00_00_00_A3, CRC_NONE, 1'b0, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0},
    '{LS_K,   3'd3, 48'h00_00_00_55_44_C3, CRC_16,   1'b0, 1'b0, 3'd0, 32'h00_00_00_00, 1'b0}
};

// Reflected CRC5, bits[0] first on the wire, result lands in bits 7:3 of token byte 2
function automatic logic [4:0] token_crc5(input logic [10:0] bits);
    logic [4:0] r;
    int         i;
    r = 5'h1f;
    for (i = 0; i < 11; i++) begin
        if (r[0] ^ bits[i]) begin
            r = (r >> 1) ^ 5'h14;
        end else begin
            r = r >> 1;
        end
    end
    return ~r;
endfunction

// Normal-form CRC16 over bytes 1 to n-1, returns {second, first} CRC byte on the wire
function automatic logic [15:0] data_crc16(input logic [47:0] bytes, input int n);
    logic [15:0] c;
    logic [15:0] tx;
    logic        fb;
    int          j;
    int          k;
    c = 16'hFFFF;
    for (j = 1; j < n; j++) begin
        for (k = 0; k < 8; k++) begin
            fb = c[15] ^ bytes[8*j+k];
            c  = c << 1;
            if (fb) begin
                c = c ^ 16'h8005;
            end
        end
    end
    // Highest coefficient goes out first, as bit 0 of the first CRC byte
    for (k = 0; k < 16; k++) begin
        tx[k] = ~c[15-k];
    end
    return tx;
endfunction

`endif

// File: dv/usb_rx_tb.sv
`timescale 1ns/100ps
////////////////////////////////////////
// USB receive monitor testbench
// Drives ULPI packets from a table and
// checks output beats and line status
////////////////////////////////////////
`include "usb_rx_macros.svh"

module usb_rx_tb;
    import usb_rx_pkg::*;

    `include "usb_rx_tb_packets.svh"

    logic                      phy_clk;
    logic                      reset;
    logic [`USB_RX_BYTE_W-1:0] phy_di;
    logic                      phy_dir;
    logic                      phy_nxt;
    logic [6:0]                cfg_usb_addr;
    logic [`USB_RX_BYTE_W-1:0] rx_data;
    logic                      rx_valid;
    logic                      rx_last;
    logic                      rx_error_flag;
    linestate_t                linestate;
    logic                      host_disconnected;

    // Beats as {last, error, data}
    logic [9:0] beat_q [$];
    int         mismatch_count;
    int         beat_count_errors;
    int         cur_pkt;
    int         seed;
    int         idx;

    usb_rx usb_rx_i (
        .phy_clk           (phy_clk),
        .reset             (reset),
        .phy_di            (phy_di),
        .phy_dir           (phy_dir),
        .phy_nxt           (phy_nxt),
        .cfg_usb_addr      (cfg_usb_addr),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rx_last           (rx_last),
        .rx_error_flag     (rx_error_flag),
        .linestate         (linestate),
        .host_disconnected (host_disconnected)
    );

    initial begin
        phy_clk = 1'b0;
    end

    always #4 phy_clk = ~phy_clk;

    // Output monitor, sampled mid-cycle
    always @(negedge phy_clk) begin
        if (!reset && rx_valid) begin
            beat_q.push_back({rx_last, rx_error_flag, rx_data});
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s (packet %0d): got 0x%0h, expected 0x%0h", name, cur_pkt, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s (packet %0d): got 0x%0h, expected 0x%0h", name, cur_pkt, got, exp);
        end
    endtask

    task automatic check_linestate(input string name, input linestate_t got, input linestate_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s (packet %0d): got 0x%0h, expected 0x%0h", name, cur_pkt, got, exp);
        end
    endtask

    // One bus cycle, inputs change 1 ns after the rising edge
    task automatic bus_cycle(input logic dir, input logic nxt, input logic [7:0] data);
        phy_dir = dir;
        phy_nxt = nxt;
        phy_di  = data;
        @(posedge phy_clk);
        #1;
    endtask

    function automatic logic [7:0] rxcmd(input logic [1:0] evt, input linestate_t ls);
        return {2'b00, evt, 2'b00, ls};
    endfunction

    // RX CMD alone with the bus turned around, then status checked once settled
    task automatic send_status(input logic [1:0] evt, input linestate_t ls, input logic disc);
        bus_cycle(1'b1, 1'b0, 8'h00);
        bus_cycle(1'b1, 1'b0, rxcmd(evt, ls));
        bus_cycle(1'b0, 1'b0, 8'h00);
        bus_cycle(1'b0, 1'b0, 8'h00);
        bus_cycle(1'b0, 1'b0, 8'h00);
        check_linestate("linestate", linestate, ls);
        check_flag("host_disconnected", host_disconnected, disc);
    endtask

    task automatic send_packet(input pkt_entry_t e);
        logic [7:0]  pkt [0:7];
        logic [15:0] crc;
        int          n;
        int          i;
        int          gap;
        n = e.nbytes;
        for (i = 0; i < n; i++) begin
            pkt[i] = e.pkt[8*i +: 8];
        end
        if (e.crc_kind == CRC_5) begin
            pkt[2][7:3] = token_crc5({pkt[2][2:0], pkt[1]});
            if (e.bad_crc) begin
                pkt[2][3] = ~pkt[2][3];
            end
        end else if (e.crc_kind == CRC_16) begin
            crc        = data_crc16(e.pkt, n);
            pkt[n]     = crc[7:0] ^ (e.bad_crc ? 8'hFF : 8'h00);
            pkt[n + 1] = crc[15:8];
            n          = n + 2;
        end
        // Turnaround, then RX CMD for rx-active
        bus_cycle(1'b1, 1'b0, 8'h00);
        bus_cycle(1'b1, 1'b0, rxcmd(2'b01, e.ls));
        for (i = 0; i < n; i++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                bus_cycle(1'b1, 1'b0, rxcmd(2'b01, e.ls));
            end
            if (e.err_cmd && (i == 1)) begin
                bus_cycle(1'b1, 1'b0, rxcmd(2'b11, e.ls));
            end
            bus_cycle(1'b1, 1'b1, pkt[i]);
        end
        bus_cycle(1'b1, 1'b0, rxcmd(2'b00, e.ls));
        bus_cycle(1'b0, 1'b0, 8'h00);
    endtask

    task automatic check_packet(input pkt_entry_t e);
        logic [9:0] beat;
        logic       is_last;
        int         waited;
        int         i;
        waited = 0;
        while ((beat_q.size() < e.exp_n) && (waited < 40)) begin
            bus_cycle(1'b0, 1'b0, 8'h00);
            waited++;
        end
        // Quiet cycles so late or extra beats show up
        repeat (6) begin
            bus_cycle(1'b0, 1'b0, 8'h00);
        end
        if (beat_q.size() != e.exp_n) begin
            beat_count_errors++;
            $display("packet %0d: expected %0d beats but the DUT gave %0d",
                     cur_pkt, e.exp_n, beat_q.size());
            beat_q.delete();
        end else begin
            for (i = 0; i < e.exp_n; i++) begin
                beat    = beat_q.pop_front();
                is_last = (i == e.exp_n - 1);
                check_byte("rx_data", beat[7:0], e.exp_data[8*i +: 8]);
                check_flag("rx_last", beat[9], is_last);
                check_flag("rx_error_flag", beat[8], is_last ? e.exp_err : 1'b0);
            end
        end
        check_linestate("linestate", linestate, e.ls);
        check_flag("host_disconnected", host_disconnected, 1'b0);
    endtask

    initial begin
        phy_di            = 8'h00;
        phy_dir           = 1'b0;
        phy_nxt           = 1'b0;
        cfg_usb_addr      = 7'h2A;
        reset             = 1'b1;
        mismatch_count    = 0;
        beat_count_errors = 0;
        cur_pkt           = -1;
        seed              = 42943;
        void'($urandom(seed));
        repeat (2) begin
            @(posedge phy_clk);
        end
        #1;
        reset = 1'b0;
        check_linestate("linestate", linestate, LS_SE1);
        check_flag("host_disconnected", host_disconnected, 1'b1);

        // Status from RX CMD bytes outside a packet
        send_status(2'b00, LS_J, 1'b0);
        send_status(2'b10, LS_SE0, 1'b1);
        send_status(2'b00, LS_K, 1'b0);

        for (idx = 0; idx < NUM_PKTS; idx++) begin
            cur_pkt = idx;
            send_packet(pkt_table[idx]);
            check_packet(pkt_table[idx]);
        end

        $display("errors: %0d value mismatches, %0d wrong beat counts",
                 mismatch_count, beat_count_errors);
        if ((mismatch_count + beat_count_errors) == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
+incdir+dv
rtl/usb_rx_pkg.sv
rtl/ulpi_rxcmd_decoder.sv
rtl/usb_crc16_checker.sv
rtl/usb_rx_packet_decoder.sv
rtl/usb_rx.sv
dv/usb_rx_tb.sv
